//--- Bender.yml
package:
  name: div_unit

export_include_dirs:
  - include

sources:
  - src/div_types_pkg.sv
  - src/mdu_op_pkg.sv
  - src/div_ctrl_if.sv
  - src/div_ctrl.sv
  - src/div_iter_counter.sv
  - src/div_datapath.sv
  - src/div_unit_top.sv
  - target: test
    files:
      - bench/div_checker.sv
      - bench/tb_div_unit.sv

//--- bench/div_checker.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  mdu_op_pkg::md_op_e   op_i,
    input  logic [`DIV_XLEN-1:0] dividend_i,
    input  logic [`DIV_XLEN-1:0] divisor_i,
    input  logic [`DIV_XLEN-1:0] result_i,
    input  logic                 ready_i,
    input  logic                 exp_given_i, // table row carries its own result
    input  logic [`DIV_XLEN-1:0] exp_table_i,
    output int                   tests_o,
    output int                   fails_o
);
    import mdu_op_pkg::*;

    localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic                 busy = 1'b0;
    logic                 in_reset = 1'b0;
    md_op_e               op_q;
    logic [`DIV_XLEN-1:0] a_q;
    logic [`DIV_XLEN-1:0] b_q;
    logic [`DIV_XLEN-1:0] exp_q;
    logic                 tab_given_q;
    logic [`DIV_XLEN-1:0] tab_q;
    logic [`DIV_XLEN-1:0] held_q = '0; // last result seen on a ready pulse
    int                   wait_cnt;
    int                   lat_q;

    // truncating division, RISC-V rules for zero divisor and overflow
    function automatic logic [`DIV_XLEN-1:0] expected_result(
        md_op_e op, logic [`DIV_XLEN-1:0] a, logic [`DIV_XLEN-1:0] b);
        logic sgn;
        logic want_rem;
        sgn      = (op == OP_DIV) || (op == OP_REM);
        want_rem = (op == OP_REM) || (op == OP_REMU);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (sgn && a == MOST_NEG && b == '1) begin
            return want_rem ? '0 : a;
        end
        if (sgn) begin
            if (want_rem) begin
                return $signed(a) % $signed(b); // sign of the dividend
            end
            return $signed(a) / $signed(b);
        end
        return want_rem ? a % b : a / b;
    endfunction

    function automatic int expected_latency(
        md_op_e op, logic [`DIV_XLEN-1:0] a, logic [`DIV_XLEN-1:0] b);
        logic sgn;
        sgn = (op == OP_DIV) || (op == OP_REM);
        if (b == '0 || (sgn && a == MOST_NEG && b == '1) || (!sgn && b > a)) begin
            return 1; // early finish
        end
        return 11;
    endfunction

    initial begin
        tests_o = 0;
        fails_o = 0;
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            busy     = 1'b0;
            in_reset = 1'b1;
            held_q   = '0;
        end else if (in_reset) begin
            in_reset = 1'b0;
            if (ready_i !== 1'b0 || result_i !== '0) begin
                fails_o++;
                $display("Fail at %0t: after reset ready_o=%b result_o=%h",
                         $time, ready_i, result_i);
            end
        end else if (busy) begin
            wait_cnt++;
            if (ready_i === 1'b1) begin
                busy   = 1'b0;
                held_q = result_i;
                tests_o++;
                if (result_i !== exp_q || (tab_given_q && result_i !== tab_q)) begin
                    fails_o++;
                    $display("Fail at %0t: test %0d %s %h, %h gave %h, expected %h",
                             $time, tests_o, op_q.name(), a_q, b_q, result_i,
                             tab_given_q ? tab_q : exp_q);
                end else if (wait_cnt != lat_q) begin
                    fails_o++;
                    $display("test %0d: ready_o came %0d cycles after start, not %0d",
                             tests_o, wait_cnt, lat_q);
                end else begin
                    $display("test %0d %s %h, %h -> %h ok in %0d cycles",
                             tests_o, op_q.name(), a_q, b_q, result_i, wait_cnt);
                end
            end else if (wait_cnt > lat_q) begin
                busy = 1'b0;
                fails_o++;
                $display("ready_o never came %0d cycles after the start of test %0d",
                         lat_q, tests_o + 1);
            end
        end else begin
            if (ready_i !== 1'b0) begin
                fails_o++;
                $display("ready_o was high at %0t with no divide pending", $time);
            end
            if (result_i !== held_q) begin
                fails_o++;
                $display("Fail at %0t: result_o moved from %h to %h while idle",
                         $time, held_q, result_i);
                held_q = result_i;
            end
            if (start_i === 1'b1) begin
                busy        = 1'b1;
                wait_cnt    = 0;
                op_q        = op_i;
                a_q         = dividend_i;
                b_q         = divisor_i;
                exp_q       = expected_result(op_i, dividend_i, divisor_i);
                lat_q       = expected_latency(op_i, dividend_i, divisor_i);
                tab_given_q = exp_given_i;
                tab_q       = exp_table_i;
            end
        end
    end

endmodule

//--- bench/tb_div_unit.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module tb_div_unit;
    import mdu_op_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_ROWS    = 200;
    localparam int READY_WAIT   = 20; // cycles before a row counts as stalled

    logic                 clk_i;
    logic                 rst_i;
    logic                 start_i;
    md_op_e               op_i;
    logic [`DIV_XLEN-1:0] dividend_i;
    logic [`DIV_XLEN-1:0] divisor_i;
    logic [`DIV_XLEN-1:0] result_o;
    logic                 ready_o;
    logic                 exp_given;
    logic [`DIV_XLEN-1:0] exp_table;
    int                   tests;
    int                   fails;
    int                   stall_fails;
    int                   n_rows;
    logic                 table_ready;

    md_op_e               tab_op[$];
    logic [`DIV_XLEN-1:0] tab_a[$];
    logic [`DIV_XLEN-1:0] tab_b[$];
    logic [`DIV_XLEN-1:0] tab_exp[$];
    logic                 tab_given[$];
    int                   tab_poke[$]; // cycle of an extra start while busy, 0 for none

    div_unit_top UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .op_i       (op_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .result_o   (result_o),
        .ready_o    (ready_o)
    );

    div_checker u_checker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .op_i        (op_i),
        .dividend_i  (dividend_i),
        .divisor_i   (divisor_i),
        .result_i    (result_o),
        .ready_i     (ready_o),
        .exp_given_i (exp_given),
        .exp_table_i (exp_table),
        .tests_o     (tests),
        .fails_o     (fails)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic add_row(input md_op_e op, input logic [`DIV_XLEN-1:0] a,
                           input logic [`DIV_XLEN-1:0] b, input logic [`DIV_XLEN-1:0] exp,
                           input logic given, input int poke);
        tab_op.push_back(op);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_exp.push_back(exp);
        tab_given.push_back(given);
        tab_poke.push_back(poke);
    endtask

    task automatic build_table();
        logic [`DIV_XLEN-1:0] b;
        add_row(OP_DIVU, 32'd100, 32'd7, 32'd14, 1'b1, 0);
        add_row(OP_REMU, 32'd100, 32'd7, 32'd2, 1'b1, 0);
        add_row(OP_DIVU, 32'hFFFF_FFFF, 32'd10, 32'h1999_9999, 1'b1, 0);
        add_row(OP_REMU, 32'hFFFF_FFFF, 32'd10, 32'd5, 1'b1, 0);
        add_row(OP_DIV, 32'd100, 32'd7, 32'd14, 1'b1, 0);
        add_row(OP_DIV, 32'hFFFF_FF9C, 32'd7, 32'hFFFF_FFF2, 1'b1, 0); // -100 / 7
        add_row(OP_DIV, 32'd100, 32'hFFFF_FFF9, 32'hFFFF_FFF2, 1'b1, 0);
        add_row(OP_DIV, 32'hFFFF_FF9C, 32'hFFFF_FFF9, 32'd14, 1'b1, 0);
        add_row(OP_REM, 32'd100, 32'd7, 32'd2, 1'b1, 0);
        add_row(OP_REM, 32'hFFFF_FF9C, 32'd7, 32'hFFFF_FFFE, 1'b1, 0);
        add_row(OP_REM, 32'd100, 32'hFFFF_FFF9, 32'd2, 1'b1, 0);
        add_row(OP_REM, 32'hFFFF_FF9C, 32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b1, 0);
        add_row(OP_DIVU, 32'd123, 32'd0, 32'hFFFF_FFFF, 1'b1, 0); // zero divisor
        add_row(OP_REMU, 32'd123, 32'd0, 32'd123, 1'b1, 0);
        add_row(OP_DIV, 32'hFFFF_FFFB, 32'd0, 32'hFFFF_FFFF, 1'b1, 0);
        add_row(OP_REM, 32'hFFFF_FFFB, 32'd0, 32'hFFFF_FFFB, 1'b1, 0);
        add_row(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b1, 0); // overflow
        add_row(OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'd0, 1'b1, 0);
        add_row(OP_DIVU, 32'd5, 32'd9, 32'd0, 1'b1, 0); // divisor above dividend
        add_row(OP_REMU, 32'd5, 32'd9, 32'd5, 1'b1, 0);
        add_row(OP_DIV, 32'd5, 32'd9, 32'd0, 1'b1, 0);
        add_row(OP_REM, 32'd5, 32'd9, 32'd5, 1'b1, 0);
        add_row(OP_DIVU, 32'd1000, 32'd3, 32'd333, 1'b1, 4); // start while iterating
        add_row(OP_REMU, 32'd1000, 32'd7, 32'd6, 1'b1, 11); // start in the DONE cycle
        add_row(OP_DIVU, 32'd6, 32'd0, 32'hFFFF_FFFF, 1'b1, 1);
        for (int i = 0; i < RAND_ROWS; i++) begin
            b = ($urandom % 4 == 0) ? $urandom % 16 : $urandom; // small divisors often
            add_row(md_op_e'($urandom % 4), $urandom, b, '0, 1'b0, 0);
        end
    endtask

    task automatic apply_row(input int idx);
        int   c;
        logic seen;
        @(negedge clk_i);
        op_i       = tab_op[idx];
        dividend_i = tab_a[idx];
        divisor_i  = tab_b[idx];
        exp_given  = tab_given[idx];
        exp_table  = tab_exp[idx];
        start_i    = 1'b1;
        c          = 0;
        seen       = 1'b0;
        while (!seen && c < READY_WAIT) begin
            @(negedge clk_i);
            c++;
            start_i = 1'b0;
            if (c == tab_poke[idx]) begin
                start_i    = 1'b1; // must be ignored
                op_i       = OP_DIVU;
                dividend_i = 32'd77;
                divisor_i  = 32'd5;
            end
            seen = ready_o;
        end
        @(negedge clk_i);
        start_i = 1'b0;
        if (!seen) begin
            stall_fails++;
            $display("row %0d: ready_o did not come within %0d cycles", idx, READY_WAIT);
        end
    endtask

    initial begin
        void'($urandom(91692));
        rst_i       = 1'b0;
        start_i     = 1'b0;
        op_i        = OP_DIV;
        dividend_i  = '0;
        divisor_i   = '0;
        exp_given   = 1'b0;
        exp_table   = '0;
        stall_fails = 0;
        table_ready = 1'b0;
        build_table();
        n_rows      = tab_op.size();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        repeat (4) @(negedge clk_i); // result_o must hold while idle
        $display("rows %0d, tests checked %0d, failures %0d, stalled rows %0d",
                 n_rows, tests, fails, stall_fails);
        if (fails == 0 && stall_fails == 0 && tests == n_rows) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // limit from the row count, 15 cycles per row plus reset
    initial begin
        wait (table_ready);
        #((n_rows * 15 + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("watchdog expired before all rows were applied");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- include/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand width
`define DIV_XLEN 32

// quotient bits retired per iteration cycle
`define DIV_BITS_PER_CYCLE 4

// iteration cycles per divide
`define DIV_ITER_CYCLES (`DIV_XLEN / `DIV_BITS_PER_CYCLE)

// wide enough to hold DIV_ITER_CYCLES
`define DIV_CNT_W 4

`endif

//--- sources.f
+incdir+include
src/div_types_pkg.sv
src/mdu_op_pkg.sv
src/div_ctrl_if.sv
src/div_ctrl.sv
src/div_iter_counter.sv
src/div_datapath.sv
src/div_unit_top.sv
bench/div_checker.sv
bench/tb_div_unit.sv

//--- src/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic       cnt_last_i,
    output logic       cnt_load_o,
    output logic       cnt_dec_o,
    div_ctrl_if.ctrl   bus
);
    import div_types_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        cnt_load_o   = 1'b0;
        cnt_dec_o    = 1'b0;
        bus.load     = 1'b0;
        bus.iterate  = 1'b0;
        bus.correct  = 1'b0;
        bus.sign_fix = 1'b0;
        bus.done     = 1'b0;

        case (state_q)
            IDLE: begin
                if (start_i) begin
                    bus.load   = 1'b1;
                    cnt_load_o = 1'b1;
                    if (bus.div_case == CASE_NORMAL) begin
                        state_d = ITER;
                    end else begin
                        state_d = DONE; // result already loaded
                    end
                end
            end
            ITER: begin
                bus.iterate = 1'b1;
                cnt_dec_o   = 1'b1;
                if (cnt_last_i) begin
                    state_d = CORRECT;
                end
            end
            CORRECT: begin
                bus.correct = 1'b1;
                state_d     = SIGN_FIX;
            end
            SIGN_FIX: begin
                bus.sign_fix = 1'b1;
                state_d      = DONE;
            end
            DONE: begin
                bus.done = 1'b1; // single cycle ready
                state_d  = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

//--- src/div_ctrl_if.sv
`timescale 1ns/1ps

interface div_ctrl_if;
    import div_types_pkg::*;

    logic      load;     // latch operands or special result
    logic      iterate;  // four non-restoring steps
    logic      correct;  // remainder restore, last quotient bit
    logic      sign_fix;
    logic      done;     // result valid for this cycle
    div_case_e div_case; // class of the current inputs

    modport ctrl (
        output load,
        output iterate,
        output correct,
        output sign_fix,
        output done,
        input  div_case
    );

    modport dp (
        input  load,
        input  iterate,
        input  correct,
        input  sign_fix,
        output div_case
    );

endinterface

//--- src/div_datapath.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_datapath (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  mdu_op_pkg::md_op_e    op_i,
    input  logic [`DIV_XLEN-1:0]  dividend_i,
    input  logic [`DIV_XLEN-1:0]  divisor_i,
    output logic [`DIV_XLEN-1:0]  result_o,
    div_ctrl_if.dp                bus
);
    import div_types_pkg::*;
    import mdu_op_pkg::*;

    logic                 op_signed;
    logic                 op_rem;
    div_case_e            op_case;
    logic [`DIV_XLEN-1:0] dvd_mag;
    logic [`DIV_XLEN-1:0] dvs_mag;

    logic                 is_signed_q;
    logic                 rem_sel_q;
    logic                 sign_a_q;    // dividend sign
    logic                 sign_b_q;    // divisor sign
    logic [`DIV_XLEN:0]   acc_q;       // partial remainder, one extra sign bit
    logic [`DIV_XLEN-1:0] quo_q;
    logic [`DIV_XLEN-1:0] dvs_q;       // divisor magnitude

    logic [`DIV_XLEN:0]   acc_nxt;
    logic [`DIV_XLEN-1:0] quo_nxt;

    assign op_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign op_rem    = (op_i == OP_REM) || (op_i == OP_REMU);

    assign dvd_mag = (op_signed && dividend_i[`DIV_XLEN-1]) ? -dividend_i : dividend_i;
    assign dvs_mag = (op_signed && divisor_i[`DIV_XLEN-1]) ? -divisor_i : divisor_i;

    always_comb begin
        if (divisor_i == '0) begin
            op_case = CASE_DIV_ZERO;
        end else if (op_signed && dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}
                     && divisor_i == '1) begin
            op_case = CASE_OVERFLOW;
        end else if (!op_signed && divisor_i > dividend_i) begin
            op_case = CASE_SMALL;
        end else begin
            op_case = CASE_NORMAL;
        end
    end

    assign bus.div_case = op_case;

    // quotient bit of each step comes from the sign before it
    always_comb begin
        logic               neg_v;
        logic [`DIV_XLEN:0] sh_v;

        acc_nxt = acc_q;
        quo_nxt = quo_q;
        for (int i = 0; i < `DIV_BITS_PER_CYCLE; i++) begin
            neg_v   = acc_nxt[`DIV_XLEN];
            sh_v    = {acc_nxt[`DIV_XLEN-1:0], quo_nxt[`DIV_XLEN-1]};
            quo_nxt = {quo_nxt[`DIV_XLEN-2:0], ~neg_v};
            acc_nxt = neg_v ? sh_v + {1'b0, dvs_q} : sh_v - {1'b0, dvs_q};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            is_signed_q <= 1'b0;
            rem_sel_q   <= 1'b0;
            sign_a_q    <= 1'b0;
            sign_b_q    <= 1'b0;
            acc_q       <= '0;
            quo_q       <= '0;
        end else if (bus.load) begin
            is_signed_q <= op_signed;
            rem_sel_q   <= op_rem;
            sign_a_q    <= dividend_i[`DIV_XLEN-1];
            sign_b_q    <= divisor_i[`DIV_XLEN-1];
            case (op_case)
                CASE_DIV_ZERO: begin
                    quo_q <= '1;
                    acc_q <= {1'b0, dividend_i};
                end
                CASE_OVERFLOW: begin
                    quo_q <= dividend_i;
                    acc_q <= '0;
                end
                CASE_SMALL: begin
                    quo_q <= '0;
                    acc_q <= {1'b0, dividend_i};
                end
                default: begin
                    quo_q <= dvd_mag;
                    acc_q <= '0;
                end
            endcase
        end else if (bus.iterate) begin
            acc_q <= acc_nxt;
            quo_q <= quo_nxt;
        end else if (bus.correct) begin
            if (acc_q[`DIV_XLEN]) begin
                acc_q <= acc_q + {1'b0, dvs_q};
            end
            quo_q <= {quo_q[`DIV_XLEN-2:0], ~acc_q[`DIV_XLEN]};
        end else if (bus.sign_fix && is_signed_q) begin
            if (sign_a_q ^ sign_b_q) begin
                quo_q <= -quo_q;
            end
            if (sign_a_q) begin
                acc_q <= {1'b0, -acc_q[`DIV_XLEN-1:0]}; // remainder follows dividend
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.load) begin
            dvs_q <= dvs_mag;
        end
    end

    assign result_o = rem_sel_q ? acc_q[`DIV_XLEN-1:0] : quo_q;

endmodule

//--- src/div_iter_counter.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_iter_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic cnt_load_i,
    input  logic cnt_dec_i,
    output logic cnt_last_o
);

    logic [`DIV_CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else if (cnt_load_i) begin
            cnt_q <= `DIV_CNT_W'(`DIV_ITER_CYCLES);
        end else if (cnt_dec_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // final iterate cycle in progress
    assign cnt_last_o = (cnt_q == `DIV_CNT_W'(1));

endmodule

//--- src/div_types_pkg.sv
package div_types_pkg;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ITER     = 3'd1,
        CORRECT  = 3'd2, // final remainder restore
        SIGN_FIX = 3'd3,
        DONE     = 3'd4
    } div_state_e;

    typedef enum logic [1:0] {
        CASE_NORMAL   = 2'd0,
        CASE_DIV_ZERO = 2'd1,
        CASE_OVERFLOW = 2'd2, // most negative / -1
        CASE_SMALL    = 2'd3  // unsigned, divisor > dividend
    } div_case_e;

endpackage

//--- src/div_unit_top.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  mdu_op_pkg::md_op_e   op_i,
    input  logic [`DIV_XLEN-1:0] dividend_i,
    input  logic [`DIV_XLEN-1:0] divisor_i,
    output logic [`DIV_XLEN-1:0] result_o,
    output logic                 ready_o
);

    logic cnt_load;
    logic cnt_dec;
    logic cnt_last;

    div_ctrl_if u_bus ();

    div_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .cnt_last_i (cnt_last),
        .cnt_load_o (cnt_load),
        .cnt_dec_o  (cnt_dec),
        .bus        (u_bus.ctrl)
    );

    div_iter_counter u_cnt (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cnt_load_i (cnt_load),
        .cnt_dec_i  (cnt_dec),
        .cnt_last_o (cnt_last)
    );

    div_datapath u_dp (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .op_i       (op_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .result_o   (result_o),
        .bus        (u_bus.dp)
    );

    assign ready_o = u_bus.done;

endmodule

//--- src/mdu_op_pkg.sv
package mdu_op_pkg;

    // RV32M divide group
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } md_op_e;

endpackage
